/* tb/cfg_ram_patterns.txt */
// Columns: opcode, address, data, expected read value, all hex
// Opcodes: 1 CPU write, 2 CPU read, 3 engine read, 4 engine read with colliding CPU write,
// 5 control write (data bit 0 force, bit 1 disable), 6 error clear,
// 7 CPU read under engine burst (data bits 4:0 engine address, bit 5 active), F end
1 00 11111111 00000000
2 00 00000000 11111111
1 1F A5A5A5A5 00000000
2 1F 00000000 A5A5A5A5
1 0A 0BADF00D 00000000
2 0A 00000000 0BADF00D
1 15 5A5A0FF0 00000000
2 15 00000000 5A5A0FF0
3 0A 00000000 0BADF00D
3 1F 00000000 A5A5A5A5
1 05 12345678 00000000
7 05 0000002A 12345678
7 05 0000000A 12345678
4 10 CAFEBABE CAFEBABE
2 10 00000000 CAFEBABE
5 00 00000001 00000000
1 07 00C0FFEE 00000000
5 00 00000000 00000000
2 07 00000000 00C0FFEE
5 00 00000002 00000000
2 07 00000000 00C0FFEE
3 07 00000000 00C0FFEE
5 00 00000000 00000000
3 07 00000000 00C0FFEE
6 00 00000000 00000000
2 0A 00000000 0BADF00D
F 00 00000000 00000000

/* verilog.f */
hdl/cfg_ram_pkg.sv
hdl/cfg_ram_array.sv
hdl/cfg_ram_port.sv
hdl/cfg_err_monitor.sv
hdl/cfg_ram_top.sv
tb/cfg_ram_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the config table testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f verilog.f --top-module cfg_ram_tb -o cfg_ram_sim

# Log decides the outcome
./obj_dir/cfg_ram_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^STATUS: PASS$" sim.log
then
    echo "Result: passed"
    exit 0
fi
echo "Result: failed"
exit 1

/* tb/cfg_ram_tb.sv */
//////////////////////////////
// Config table testbench
// Pattern-driven CPU, engine and
// parity checks against a model
//////////////////////////////

`timescale 1ns/1ps

module cfg_ram_tb
    import cfg_ram_pkg::*;
();

    localparam int AW        = ADDR_BITS_DEF;
    localparam int DW        = DATA_WIDTH_DEF;
    localparam int DEPTH     = 1 << AW;
    localparam int MAX_REC   = 64;
    localparam int TIMEOUT   = 100;
    localparam int BURST_LEN = 6;

    logic                    clk;
    logic                    rst;
    logic                    active;
    logic                    eng_re;
    logic [AW-1:0]           eng_ra;
    logic [DW-1:0]           eng_rdd;
    logic                    upen;
    logic [AW-1:0]           upa;
    logic                    upws;
    logic                    uprs;
    logic [DW-1:0]           updi;
    logic [DW-1:0]           updo;
    logic                    uprdy;
    logic                    ctrl_we;
    logic [1:0]              ctrl_wd;
    logic                    err_clr;
    logic                    err_sticky;
    logic [ERR_CNT_BITS-1:0] err_cnt;

    // Four words per pattern record
    logic [31:0]   pat [MAX_REC*4];
    // Reference model with data and a bad parity flag per word
    logic [DW-1:0] model_mem [DEPTH];
    logic          model_bad [DEPTH];
    logic          force_m;
    logic          dis_m;
    int            exp_cnt;
    int            seed;

    cfg_ram_top #(
        .ADDR_BITS (AW),
        .WIDTH     (DW)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .active     (active),
        .eng_re     (eng_re),
        .eng_ra     (eng_ra),
        .eng_rdd    (eng_rdd),
        .upen       (upen),
        .upa        (upa),
        .upws       (upws),
        .uprs       (uprs),
        .updi       (updi),
        .updo       (updo),
        .uprdy      (uprdy),
        .ctrl_we    (ctrl_we),
        .ctrl_wd    (ctrl_wd),
        .err_clr    (err_clr),
        .err_sticky (err_sticky),
        .err_cnt    (err_cnt)
    );

    // 40 ns period
    always #20 clk = ~clk;

    //////////////////////////////
    // Reporting
    //////////////////////////////

    task stop_run;
        begin
            $display("STATUS: FAIL");
            $fatal(1, "Simulation stopped");
        end
    endtask

    task compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        begin
            if (got !== exp)
            begin
                $display("ERROR: %s = 0x%08h, expected 0x%08h", name, got, exp);
                stop_run();
            end
        end
    endtask

    // Bounded wait for the one-cycle ready pulse
    task wait_uprdy;
        int n;
        begin
            n = 0;
            @(negedge clk);
            while (!uprdy)
            begin
                n++;
                if (n > TIMEOUT)
                begin
                    $display("Timed out waiting for uprdy");
                    stop_run();
                end
                @(negedge clk);
            end
        end
    endtask

    //////////////////////////////
    // Bus operations
    //////////////////////////////

    task cpu_write(input logic [AW-1:0] a, input logic [DW-1:0] d);
        begin
            @(posedge clk);
            upen <= 1'b1;
            upa  <= a;
            updi <= d;
            upws <= 1'b1;
            @(posedge clk);
            upws <= 1'b0;
            wait_uprdy();
            @(posedge clk);
            upen <= 1'b0;
            model_mem[a] = d;
            model_bad[a] = force_m;
        end
    endtask

    task cpu_read(input logic [AW-1:0] a, input logic [DW-1:0] exp);
        begin
            @(posedge clk);
            upen <= 1'b1;
            upa  <= a;
            uprs <= 1'b1;
            @(posedge clk);
            uprs <= 1'b0;
            wait_uprdy();
            compare_value("updo", updo, exp);
            @(posedge clk);
            upen <= 1'b0;
            // Output must drop once the frame ends
            @(negedge clk);
            compare_value("updo", updo, 32'h0);
            if (!dis_m && model_bad[a])
                exp_cnt++;
        end
    endtask

    // Data due exactly RD_LATENCY cycles after the strobe
    task eng_read(input logic [AW-1:0] a, input logic [DW-1:0] exp);
        logic [DW-1:0] held;
        begin
            @(posedge clk);
            active <= 1'b1;
            eng_re <= 1'b1;
            eng_ra <= a;
            // Output still shows the previous read
            @(negedge clk);
            held = eng_rdd;
            @(posedge clk);
            eng_re <= 1'b0;
            repeat (RD_LATENCY - 2) @(posedge clk);
            // New word not due yet
            @(negedge clk);
            compare_value("eng_rdd", eng_rdd, held);
            @(posedge clk);
            @(negedge clk);
            compare_value("eng_rdd", eng_rdd, exp);
            if (!dis_m && model_bad[a])
                exp_cnt++;
        end
    endtask

    // Engine read lands on the write commit cycle
    task collide_read(input logic [AW-1:0] a, input logic [DW-1:0] d,
                      input logic [DW-1:0] exp);
        begin
            @(posedge clk);
            upen <= 1'b1;
            upa  <= a;
            updi <= d;
            upws <= 1'b1;
            @(posedge clk);
            upws <= 1'b0;
            repeat (WR_COMMIT_DELAY - 1) @(posedge clk);
            active <= 1'b1;
            eng_re <= 1'b1;
            eng_ra <= a;
            @(posedge clk);
            eng_re <= 1'b0;
            repeat (RD_LATENCY - 1) @(posedge clk);
            @(negedge clk);
            compare_value("eng_rdd", eng_rdd, exp);
            wait_uprdy();
            @(posedge clk);
            upen <= 1'b0;
            model_mem[a] = d;
            model_bad[a] = force_m;
        end
    endtask

    // CPU read against a burst of engine reads elsewhere
    task burst_read(input logic [AW-1:0] a, input logic [AW-1:0] ea, input logic act,
                    input logic [DW-1:0] exp);
        int n;
        begin
            n = 0;
            @(posedge clk);
            upen   <= 1'b1;
            upa    <= a;
            uprs   <= 1'b1;
            active <= act;
            eng_re <= 1'b1;
            eng_ra <= ea;
            @(negedge clk);
            while (!uprdy)
            begin
                @(posedge clk);
                n++;
                uprs <= 1'b0;
                if (n >= BURST_LEN)
                    eng_re <= 1'b0;
                if (n > TIMEOUT)
                begin
                    $display("Timed out waiting for uprdy during an engine burst");
                    stop_run();
                end
                @(negedge clk);
            end
            // Served after the burst only when the engine is active
            compare_value("uprdy_delay", n, (act ? BURST_LEN : 1) + RDY_DELAY);
            compare_value("updo", updo, exp);
            @(posedge clk);
            upen   <= 1'b0;
            eng_re <= 1'b0;
            active <= 1'b1;
            @(negedge clk);
            compare_value("updo", updo, 32'h0);
            if (act && !dis_m && model_bad[ea])
                exp_cnt += BURST_LEN;
            if (!dis_m && model_bad[a])
                exp_cnt++;
        end
    endtask

    task ctrl_write(input logic [1:0] bits);
        begin
            @(posedge clk);
            ctrl_we <= 1'b1;
            ctrl_wd <= bits;
            @(posedge clk);
            ctrl_we <= 1'b0;
            force_m = bits[0];
            dis_m   = bits[1];
        end
    endtask

    task clear_errors;
        begin
            @(posedge clk);
            err_clr <= 1'b1;
            @(posedge clk);
            err_clr <= 1'b0;
            exp_cnt = 0;
        end
    endtask

    // Let parity reports drain, then compare monitor state
    task settle_errors;
        int n;
        begin
            n = 0;
            if (exp_cnt != 0)
            begin
                @(negedge clk);
                while (!err_sticky)
                begin
                    n++;
                    if (n > TIMEOUT)
                    begin
                        $display("Timed out waiting for err_sticky");
                        stop_run();
                    end
                    @(negedge clk);
                end
            end
            repeat (4) @(posedge clk);
            @(negedge clk);
            compare_value("err_cnt", 32'(err_cnt), exp_cnt);
            compare_value("err_sticky", 32'(err_sticky), 32'(exp_cnt != 0));
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin : main_seq
        int            i;
        logic [31:0]   op;
        logic [AW-1:0] a;
        logic [31:0]   d;
        logic [31:0]   e;
        logic          done;
        seed    = 26;
        exp_cnt = 0;
        force_m = 1'b0;
        dis_m   = 1'b0;
        clk     = 1'b0;
        rst     <= 1'b1;
        active  <= 1'b0;
        eng_re  <= 1'b0;
        eng_ra  <= '0;
        upen    <= 1'b0;
        upa     <= '0;
        upws    <= 1'b0;
        uprs    <= 1'b0;
        updi    <= '0;
        ctrl_we <= 1'b0;
        ctrl_wd <= '0;
        err_clr <= 1'b0;
        // Unread slots act as end records
        for (i = 0; i < MAX_REC * 4; i++)
            pat[i] = 32'hF;
        $readmemh("tb/cfg_ram_patterns.txt", pat);

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_value("uprdy", 32'(uprdy), 32'h0);
        compare_value("updo", updo, 32'h0);
        compare_value("err_sticky", 32'(err_sticky), 32'h0);
        compare_value("err_cnt", 32'(err_cnt), 32'h0);

        // Random fill so no read sees an unwritten word
        for (i = 0; i < DEPTH; i++)
        begin
            a = i[AW-1:0];
            d = $random(seed);
            cpu_write(a, d);
        end

        done = 1'b0;
        for (i = 0; i < MAX_REC && !done; i++)
        begin
            op = pat[4*i];
            a  = pat[4*i+1][AW-1:0];
            d  = pat[4*i+2];
            e  = pat[4*i+3];
            case (op)
                32'h1: cpu_write(a, d);
                32'h2: cpu_read(a, e);
                32'h3: eng_read(a, e);
                32'h4: collide_read(a, d, e);
                32'h5: ctrl_write(d[1:0]);
                32'h6: clear_errors();
                32'h7: burst_read(a, d[AW-1:0], d[5], e);
                32'hF: done = 1'b1;
                default:
                begin
                    $display("Unknown opcode %0h in pattern record %0d", op, i);
                    stop_run();
                end
            endcase
            if (!done)
                settle_errors();
        end

        // Engine sweep of the whole table against the model
        for (i = 0; i < DEPTH; i++)
        begin
            a = i[AW-1:0];
            eng_read(a, model_mem[a]);
        end
        settle_errors();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* hdl/cfg_ram_top.sv */
//////////////////////////////
// Parity-protected config table
// Access port, memory and monitor
//////////////////////////////

`timescale 1ns/1ps

module cfg_ram_top
    import cfg_ram_pkg::*;
#(
    parameter int ADDR_BITS = ADDR_BITS_DEF,
    parameter int WIDTH     = DATA_WIDTH_DEF
)
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    active,
    // Engine read port
    input  logic                    eng_re,
    input  logic [ADDR_BITS-1:0]    eng_ra,
    output logic [WIDTH-1:0]        eng_rdd,
    // CPU port
    input  logic                    upen,
    input  logic [ADDR_BITS-1:0]    upa,
    input  logic                    upws,
    input  logic                    uprs,
    input  logic [WIDTH-1:0]        updi,
    output logic [WIDTH-1:0]        updo,
    output logic                    uprdy,
    // Monitor access
    input  logic                    ctrl_we,
    input  logic [1:0]              ctrl_wd,
    input  logic                    err_clr,
    output logic                    err_sticky,
    output logic [ERR_CNT_BITS-1:0] err_cnt
);

    // Port to memory
    logic                 mem_we;
    logic [ADDR_BITS-1:0] mem_wa;
    logic [WIDTH:0]       mem_wd;
    logic                 mem_re;
    logic [ADDR_BITS-1:0] mem_ra;
    logic [WIDTH:0]       mem_rd;
    // Monitor to port and back
    logic                 par_force;
    logic                 par_dis;
    logic                 par_err;

    cfg_ram_port #(
        .ADDR_BITS (ADDR_BITS),
        .WIDTH     (WIDTH)
    ) u_port (
        .clk       (clk),
        .rst       (rst),
        .active    (active),
        .eng_re    (eng_re),
        .eng_ra    (eng_ra),
        .eng_rdd   (eng_rdd),
        .upen      (upen),
        .upa       (upa),
        .upws      (upws),
        .uprs      (uprs),
        .updi      (updi),
        .updo      (updo),
        .uprdy     (uprdy),
        .par_force (par_force),
        .par_dis   (par_dis),
        .par_err   (par_err),
        .mem_we    (mem_we),
        .mem_wa    (mem_wa),
        .mem_wd    (mem_wd),
        .mem_re    (mem_re),
        .mem_ra    (mem_ra),
        .mem_rd    (mem_rd)
    );

    // Storage carries the parity bit on top of each word
    cfg_ram_array #(
        .ADDR_BITS (ADDR_BITS),
        .WIDTH     (WIDTH)
    ) u_array (
        .clk    (clk),
        .rst    (rst),
        .mem_we (mem_we),
        .mem_wa (mem_wa),
        .mem_wd (mem_wd),
        .mem_re (mem_re),
        .mem_ra (mem_ra),
        .mem_rd (mem_rd)
    );

    cfg_err_monitor u_monitor (
        .clk        (clk),
        .rst        (rst),
        .ctrl_we    (ctrl_we),
        .ctrl_wd    (ctrl_wd),
        .err_clr    (err_clr),
        .par_err    (par_err),
        .par_force  (par_force),
        .par_dis    (par_dis),
        .err_sticky (err_sticky),
        .err_cnt    (err_cnt)
    );

endmodule

/* hdl/cfg_err_monitor.sv */
//////////////////////////////
// Parity error monitor
// Control bits, sticky flag and
// saturating error count
//////////////////////////////

`timescale 1ns/1ps

module cfg_err_monitor
    import cfg_ram_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ctrl_we,
    input  logic [1:0]              ctrl_wd,
    input  logic                    err_clr,
    input  logic                    par_err,
    output logic                    par_force,
    output logic                    par_dis,
    output logic                    err_sticky,
    output logic [ERR_CNT_BITS-1:0] err_cnt
);

    localparam logic [ERR_CNT_BITS-1:0] CNT_MAX = '1;

    // Bit 0 forces bad parity on writes, bit 1 turns the check off
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            par_force <= 1'b0;
            par_dis   <= 1'b0;
        end
        else if (ctrl_we)
        begin
            par_force <= ctrl_wd[0];
            par_dis   <= ctrl_wd[1];
        end
    end

    // Clear wins over a same-cycle error
    always_ff @(posedge clk)
    begin
        if (rst || err_clr)
        begin
            err_sticky <= 1'b0;
            err_cnt    <= '0;
        end
        else if (par_err)
        begin
            err_sticky <= 1'b1;
            // Stick at the top
            if (err_cnt != CNT_MAX)
            begin
                err_cnt <= err_cnt + 1'b1;
            end
        end
    end

endmodule

/* hdl/cfg_ram_port.sv */
//////////////////////////////
// Configuration table access port
// CPU/engine arbitration, write delay,
// parity insert and check, write bypass
//////////////////////////////

`timescale 1ns/1ps

module cfg_ram_port
    import cfg_ram_pkg::*;
#(
    parameter int ADDR_BITS = 5,
    parameter int WIDTH     = 32
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 active,
    // Engine read side
    input  logic                 eng_re,
    input  logic [ADDR_BITS-1:0] eng_ra,
    output logic [WIDTH-1:0]     eng_rdd,
    // CPU side
    input  logic                 upen,
    input  logic [ADDR_BITS-1:0] upa,
    input  logic                 upws,
    input  logic                 uprs,
    input  logic [WIDTH-1:0]     updi,
    output logic [WIDTH-1:0]     updo,
    output logic                 uprdy,
    // Parity control and report
    input  logic                 par_force,
    input  logic                 par_dis,
    output logic                 par_err,
    // Memory side
    output logic                 mem_we,
    output logic [ADDR_BITS-1:0] mem_wa,
    output logic [WIDTH:0]       mem_wd,
    output logic                 mem_re,
    output logic [ADDR_BITS-1:0] mem_ra,
    input  logic [WIDTH:0]       mem_rd
);

    //////////////////////////////
    // Request decode and arbitration
    //////////////////////////////

    logic                       eng_rd;
    logic                       cpu_wr;
    logic                       cpu_rd;
    logic                       uprd_lat;
    logic                       uprd_ok;
    logic [WR_COMMIT_DELAY-1:0] wr_pipe;
    logic [WR_COMMIT_DELAY-1:0] par_pipe;
    logic                       rd_req;
    logic                       wr_conflict;
    logic [RD_LATENCY-1:0]      same_pipe;
    logic [WIDTH-1:0]           rd_data;
    logic [WIDTH-1:0]           rd_data_q;
    logic                       par_rd_q;
    logic [RD_LATENCY:0]        re_pipe;
    logic [RDY_DELAY-1:0]       acc_pipe;
    logic                       par_bad;

    // Engine reads count only while active
    assign eng_rd = eng_re & active;
    assign cpu_wr = upws & upen;
    assign cpu_rd = uprs & upen;

    // Pending CPU read yields unless the engine is idle
    // or already reading the same word
    assign uprd_ok = uprd_lat & (~eng_rd | (eng_ra == upa));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            uprd_lat <= 1'b0;
        end
        else if (!upen)
        begin
            // Frame dropped, forget any pending request
            uprd_lat <= 1'b0;
        end
        else if (uprd_ok)
        begin
            uprd_lat <= 1'b0;
        end
        else if (cpu_rd)
        begin
            uprd_lat <= 1'b1;
        end
    end

    //////////////////////////////
    // Write pipeline with parity
    //////////////////////////////

    // Write strobe delayed to the commit cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_pipe <= '0;
        end
        else
        begin
            wr_pipe <= {wr_pipe[WR_COMMIT_DELAY-2:0], cpu_wr};
        end
    end

    // Even parity, flipped on request to plant an error
    always_ff @(posedge clk)
    begin
        par_pipe <= {par_pipe[WR_COMMIT_DELAY-2:0], (^updi) ^ par_force};
    end

    // upa and updi stay put until uprdy, so they feed the write directly
    assign mem_we = wr_pipe[WR_COMMIT_DELAY-1];
    assign mem_wa = upa;
    assign mem_wd = {par_pipe[WR_COMMIT_DELAY-1], updi};

    //////////////////////////////
    // Read path and bypass
    //////////////////////////////

    assign rd_req = eng_rd | uprd_ok;
    // Engine owns the address whenever it reads
    assign mem_ra = eng_rd ? eng_ra : upa;

    // Read of the word being written this cycle
    assign wr_conflict = mem_we & (mem_wa == mem_ra);
    assign mem_re = rd_req & ~wr_conflict;

    // Collision flag follows the array latency
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            same_pipe <= '0;
        end
        else
        begin
            same_pipe <= {same_pipe[RD_LATENCY-2:0], rd_req & wr_conflict};
        end
    end

    // Bypassed reads return the fresh write data
    assign rd_data = same_pipe[RD_LATENCY-1] ? updi : mem_rd[WIDTH-1:0];
    assign eng_rdd = rd_data;

    // One more register for the CPU and the parity check
    always_ff @(posedge clk)
    begin
        rd_data_q <= rd_data;
        par_rd_q  <= mem_rd[WIDTH];
    end

    // Forced to zero outside a CPU frame
    assign updo = upen ? rd_data_q : '0;

    //////////////////////////////
    // Ready and parity check
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            acc_pipe <= '0;
            re_pipe  <= '0;
            par_err  <= 1'b0;
        end
        else
        begin
            acc_pipe <= {acc_pipe[RDY_DELAY-2:0], uprd_ok | mem_we};
            // Only real array reads enter the check pipe
            re_pipe  <= {re_pipe[RD_LATENCY-1:0], mem_re};
            par_err  <= par_bad;
        end
    end

    assign uprdy = acc_pipe[RDY_DELAY-1];

    // Odd overall parity on a checked read is an error
    assign par_bad = ~par_dis & re_pipe[RD_LATENCY] & (^{par_rd_q, rd_data_q});

endmodule

/* hdl/cfg_ram_array.sv */
//////////////////////////////
// Configuration table memory
// Synchronous write, three-stage
// registered read path
//////////////////////////////

`timescale 1ns/1ps

module cfg_ram_array
    import cfg_ram_pkg::*;
#(
    parameter int ADDR_BITS = 5,
    parameter int WIDTH     = 32
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mem_we,
    input  logic [ADDR_BITS-1:0] mem_wa,
    input  logic [WIDTH:0]       mem_wd,
    input  logic                 mem_re,
    input  logic [ADDR_BITS-1:0] mem_ra,
    output logic [WIDTH:0]       mem_rd
);

    localparam int DEPTH = 1 << ADDR_BITS;

    // Storage, parity bit in the top position
    logic [WIDTH:0]         mem [DEPTH];

    // Stage 1 address, enable chain for stages 2 and 3
    logic [ADDR_BITS-1:0]   ra_q;
    logic [RD_LATENCY-2:0]  re_pipe;
    // Stage 2 raw array data
    logic [WIDTH:0]         rd_q;

    // Write lands on the edge where mem_we is seen
    always_ff @(posedge clk)
    begin
        if (mem_we)
        begin
            mem[mem_wa] <= mem_wd;
        end
    end

    // Read enable travels alongside the data stages
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            re_pipe <= '0;
        end
        else
        begin
            re_pipe <= {re_pipe[RD_LATENCY-3:0], mem_re};
        end
    end

    // Address register, array read, then held output
    always_ff @(posedge clk)
    begin
        ra_q <= mem_ra;
        if (re_pipe[0])
        begin
            rd_q <= mem[ra_q];
        end
        // Output holds until the next read arrives
        if (re_pipe[RD_LATENCY-2])
        begin
            mem_rd <= rd_q;
        end
    end

endmodule

/* hdl/cfg_ram_pkg.sv */
//////////////////////////////
// Configuration table package
// Default sizes and the fixed
// latencies of the table pipeline
//////////////////////////////

package cfg_ram_pkg;

    //////////////////////////////
    // Default sizes
    //////////////////////////////

    // 32 words by default
    localparam int ADDR_BITS_DEF = 5;
    // Payload width, parity bit not included
    localparam int DATA_WIDTH_DEF = 32;

    //////////////////////////////
    // Pipeline timing
    //////////////////////////////

    // Memory read enable to data at the array output
    localparam int RD_LATENCY = 3;
    // Accepted CPU write strobe to memory write
    localparam int WR_COMMIT_DELAY = 2;
    // Accepted CPU access to uprdy
    localparam int RDY_DELAY = 4;

    // Width of the saturating parity error counter
    localparam int ERR_CNT_BITS = 8;

endpackage
